//--- files.f
src/istream_pkg.sv
src/istream_rd_if.sv
src/istream_ptrs.sv
src/istream_store.sv
src/istream_ways.sv
src/istream_top.sv
sim/istream_tb.sv

//--- run.sh
#!/bin/sh
# build and run the stream buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f files.f --top-module istream_tb \
    -Mdir obj_dir -o istream_sim
./obj_dir/istream_sim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- sim/istream_tb.sv
// Reference queue built with the chunk split rule; blocks never carry an empty valid map.
// Random chunks and valid maps come from a fixed-seed LCG.
`timescale 1ns/10ps
`default_nettype none

module istream_tb;

    localparam int RESET_CYCLES = 16;
    localparam int RAND_BLOCKS  = 24;
    localparam int TOTAL_BLOCKS = RAND_BLOCKS + 21;
    localparam int STIM_CYCLES  = RESET_CYCLES + 12 * TOTAL_BLOCKS;
    localparam int TIMEOUT_NS   = STIM_CYCLES * 4 + 400;

    logic             CLK = 1'b0;
    logic             nRST;
    logic             valid_senq;
    logic [7:0]       valid_by_chunk_senq;
    logic [7:0][15:0] instr_by_chunk_senq;
    logic [31:0]      after_pc_senq;
    logic             stall_senq;
    logic             valid_sdeq;
    logic [3:0]       valid_by_way_sdeq;
    logic [3:0]       uncompressed_by_way_sdeq;
    logic [3:0][31:0] instr_by_way_sdeq;
    logic [3:0][31:0] pc_by_way_sdeq;
    logic             stall_sdeq;
    logic             restart;
    logic [31:0]      restart_pc;

    // stimulus state
    logic [31:0] rng_state;
    logic [27:0] fetch_base;
    logic        jitter_on;
    string       test_name;

    // reference model
    logic [31:0] q_val [$];
    logic [31:0] q_pc [$];
    logic        q_unc [$];
    logic [27:0] model_base;
    logic [15:0] lo_val;
    logic [31:0] lo_pc;
    logic        lo_pending;

    // effect of the coming edge as seen mid-cycle
    logic             p_restart;
    logic [31:0]      p_restart_pc;
    int               p_pops;
    logic             p_push;
    logic [7:0]       p_map;
    logic [7:0][15:0] p_chunks;
    logic [31:0]      p_after;

    logic             exp_ok [4];
    logic [31:0]      exp_val [4];
    logic [31:0]      exp_pc [4];
    logic             exp_unc [4];
    logic [3:0]       cur_valid;
    logic [3:0]       prev_valid;
    logic [3:0]       cur_unc;
    logic [3:0][31:0] cur_instr;
    logic [3:0][31:0] prev_instr;
    logic [3:0][31:0] cur_pc;
    logic [3:0][31:0] prev_pc;
    logic             cur_stall;
    logic             prev_stall;
    logic             cur_restart;
    logic             prev_restart;
    logic             cur_vsdeq;

    istream_top UUT (
        .CLK                      (CLK),
        .nRST                     (nRST),
        .valid_senq               (valid_senq),
        .valid_by_chunk_senq      (valid_by_chunk_senq),
        .instr_by_chunk_senq      (instr_by_chunk_senq),
        .after_pc_senq            (after_pc_senq),
        .stall_senq               (stall_senq),
        .valid_sdeq               (valid_sdeq),
        .valid_by_way_sdeq        (valid_by_way_sdeq),
        .uncompressed_by_way_sdeq (uncompressed_by_way_sdeq),
        .instr_by_way_sdeq        (instr_by_way_sdeq),
        .pc_by_way_sdeq           (pc_by_way_sdeq),
        .stall_sdeq               (stall_sdeq),
        .restart                  (restart),
        .restart_pc               (restart_pc)
    );

    always #2 CLK = ~CLK;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic expect_equal(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act == exp)
            else abort_run($sformatf("[ERROR] %s %s: expected %h, actual %h",
                                     test_name, what, exp, act));
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // any_kind allows low bits 11, otherwise bit 1 is cleared
    function automatic logic [7:0][15:0] random_chunks(input bit any_kind);
        logic [7:0][15:0] c;
        logic [31:0]      r;
        for (int i = 0; i < 8; i++) begin
            r = next_random();
            c[i] = any_kind ? r[31:16] : {r[31:18], 1'b0, r[16]};
        end
        return c;
    endfunction

    function automatic logic [7:0] random_map();
        logic [31:0] r;
        r = next_random();
        return (r[23:16] == 8'h00) ? 8'h01 : r[23:16];
    endfunction

    // ----------------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------------
    task automatic drop_reference(input logic [31:0] pc);
        q_val.delete();
        q_pc.delete();
        q_unc.delete();
        lo_pending = 1'b0;
        model_base = pc[31:4];
    endtask

    task automatic split_block(input logic [7:0] vmap, input logic [7:0][15:0] chunks,
                               input logic [31:0] after_pc);
        logic [31:0] pc;
        for (int i = 0; i < 8; i++) begin
            if (vmap[i]) begin
                pc = {model_base, 3'(i), 1'b0};
                if (lo_pending) begin
                    // upper half keeps the PC of its lower chunk
                    q_val.push_back({chunks[i], lo_val});
                    q_pc.push_back(lo_pc);
                    q_unc.push_back(1'b1);
                    lo_pending = 1'b0;
                end else if (chunks[i][1:0] == 2'b11) begin
                    lo_pending = 1'b1;
                    lo_val = chunks[i];
                    lo_pc = pc;
                end else begin
                    q_val.push_back({16'h0000, chunks[i]});
                    q_pc.push_back(pc);
                    q_unc.push_back(1'b0);
                end
            end
        end
        model_base = after_pc[31:4];
    endtask

    // outputs and inputs are settled at the falling edge
    always @(negedge CLK) begin
        prev_valid   <= cur_valid;
        prev_instr   <= cur_instr;
        prev_pc      <= cur_pc;
        prev_stall   <= cur_stall;
        prev_restart <= cur_restart;
        cur_valid    <= valid_by_way_sdeq;
        cur_unc      <= uncompressed_by_way_sdeq;
        cur_instr    <= instr_by_way_sdeq;
        cur_pc       <= pc_by_way_sdeq;
        cur_stall    <= stall_sdeq;
        cur_restart  <= restart;
        cur_vsdeq    <= valid_sdeq;
        if (!nRST) begin
            drop_reference(istream_pkg::INIT_PC);
            p_restart = 1'b0;
            p_pops = 0;
            p_push = 1'b0;
        end else begin
            // apply the edge that just passed
            if (p_restart) begin
                drop_reference(p_restart_pc);
            end else begin
                repeat (p_pops) begin
                    if (q_val.size() > 0) begin
                        void'(q_val.pop_front());
                        void'(q_pc.pop_front());
                        void'(q_unc.pop_front());
                    end
                end
                if (p_push) begin
                    split_block(p_map, p_chunks, p_after);
                end
            end
            p_restart = restart;
            p_restart_pc = restart_pc;
            p_pops = stall_sdeq ? 0 : $countones(valid_by_way_sdeq);
            p_push = valid_senq && !stall_senq;
            p_map = valid_by_chunk_senq;
            p_chunks = instr_by_chunk_senq;
            p_after = after_pc_senq;
        end
        for (int w = 0; w < 4; w++) begin
            exp_ok[w] = (q_val.size() > w);
            exp_val[w] = exp_ok[w] ? q_val[w] : 32'h0;
            exp_pc[w] = exp_ok[w] ? q_pc[w] : 32'h0;
            exp_unc[w] = exp_ok[w] ? q_unc[w] : 1'b0;
        end
    end

    // ----------------------------------------------------------------------------
    // per-way checks
    // ----------------------------------------------------------------------------
    for (genvar w = 0; w < 4; w++) begin : g_way
        assert property (@(posedge CLK) disable iff (!nRST) cur_valid[w] |-> exp_ok[w])
            else abort_run($sformatf("%s: way %0d is valid but no instruction is expected",
                                     test_name, w));

        assert property (@(posedge CLK) disable iff (!nRST)
            (cur_valid[w] && exp_ok[w]) |->
                ({cur_unc[w], cur_instr[w], cur_pc[w]} == {exp_unc[w], exp_val[w], exp_pc[w]}))
            else abort_run($sformatf("[ERROR] %s way %0d: expected %h pc %h, actual %h pc %h",
                                     test_name, w, exp_val[w], exp_pc[w],
                                     cur_instr[w], cur_pc[w]));

        // a way shown under stall stays as it was
        assert property (@(posedge CLK) disable iff (!nRST)
            (prev_stall && !prev_restart && prev_valid[w]) |->
                (cur_valid[w] && cur_instr[w] == prev_instr[w] && cur_pc[w] == prev_pc[w]))
            else abort_run($sformatf("[ERROR] %s way %0d held: expected %h pc %h, actual %h pc %h",
                                     test_name, w, prev_instr[w], prev_pc[w],
                                     cur_instr[w], cur_pc[w]));
    end

    // the oldest complete instruction always lies in the two head sets
    assert property (@(posedge CLK) disable iff (!nRST) cur_vsdeq == exp_ok[0])
        else abort_run($sformatf("[ERROR] %s valid_sdeq: expected %b, actual %b",
                                 test_name, exp_ok[0], cur_vsdeq));

    // ----------------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------------
    task automatic send_block(input logic [7:0] vmap, input logic [7:0][15:0] chunks);
        logic        taken;
        logic [31:0] r;
        valid_senq = 1'b1;
        valid_by_chunk_senq = vmap;
        instr_by_chunk_senq = chunks;
        after_pc_senq = {fetch_base + 28'd1, 4'h0};
        taken = 1'b0;
        while (!taken) begin
            @(negedge CLK);
            taken = !stall_senq;
            @(posedge CLK);
            #1;
            if (jitter_on) begin
                r = next_random();
                stall_sdeq = (r[31:30] == 2'b00);
            end
        end
        fetch_base = fetch_base + 28'd1;
        valid_senq = 1'b0;
    endtask

    task automatic wait_drained();
        stall_sdeq = 1'b0;
        do begin
            @(posedge CLK);
            #1;
        end while (q_val.size() != 0);
    endtask

    initial begin
        #(TIMEOUT_NS);
        abort_run("watchdog: the run did not finish within the time limit");
    end

    initial begin
        logic [7:0][15:0] blk;
        nRST = 1'b0;
        valid_senq = 1'b0;
        valid_by_chunk_senq = 8'h00;
        instr_by_chunk_senq = '0;
        after_pc_senq = 32'h0;
        stall_sdeq = 1'b0;
        restart = 1'b0;
        restart_pc = 32'h0;
        rng_state = 32'hf039_1c85;
        fetch_base = istream_pkg::INIT_PC[31:4];
        jitter_on = 1'b0;
        test_name = "reset_and_first_pc";
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;
        expect_equal("valid_sdeq", 32'h0, {31'h0, valid_sdeq});
        expect_equal("stall_senq", 32'h0, {31'h0, stall_senq});
        // first valid chunk sits at index 3
        send_block(8'b1111_1000, random_chunks(1'b0));
        expect_equal("first pc", istream_pkg::INIT_PC + 32'd6, pc_by_way_sdeq[0]);
        wait_drained();

        test_name = "compressed_stream";
        repeat (6) send_block(8'hff, random_chunks(1'b0));
        wait_drained();

        test_name = "cross_set_32bit";
        stall_sdeq = 1'b1;
        blk = random_chunks(1'b0);
        blk[2] = 16'h1237;
        send_block(8'b0000_0111, blk);
        repeat (3) @(posedge CLK);
        #1;
        expect_equal("ways waiting for upper half", 32'h3, {28'h0, valid_by_way_sdeq});
        blk = random_chunks(1'b0);
        blk[4] = 16'hbeef;
        send_block(8'b1111_0000, blk);
        expect_equal("ways after next set", 32'hf, {28'h0, valid_by_way_sdeq});
        expect_equal("uncompressed ways", 32'h4, {28'h0, uncompressed_by_way_sdeq});
        wait_drained();

        test_name = "random_valid_maps";
        jitter_on = 1'b1;
        repeat (RAND_BLOCKS) send_block(random_map(), random_chunks(1'b1));
        jitter_on = 1'b0;
        stall_sdeq = 1'b0;
        // completes a dangling lower half, if any
        send_block(8'hff, random_chunks(1'b0));
        wait_drained();

        test_name = "full_under_stall";
        stall_sdeq = 1'b1;
        for (int k = 0; k < 8; k++) begin
            expect_equal($sformatf("stall_senq before block %0d", k), 32'h0, {31'h0, stall_senq});
            send_block(8'hff, random_chunks(1'b0));
        end
        expect_equal("stall_senq when full", 32'h1, {31'h0, stall_senq});
        repeat (4) @(posedge CLK);
        #1;
        wait_drained();

        test_name = "restart_flush";
        stall_sdeq = 1'b1;
        repeat (2) send_block(random_map(), random_chunks(1'b1));
        restart = 1'b1;
        restart_pc = 32'h4000_1230;
        @(posedge CLK);
        #1;
        restart = 1'b0;
        expect_equal("valid_sdeq after restart", 32'h0, {31'h0, valid_sdeq});
        fetch_base = restart_pc[31:4];
        stall_sdeq = 1'b0;
        send_block(8'hff, random_chunks(1'b0));
        expect_equal("pc after restart", restart_pc, pc_by_way_sdeq[0]);
        wait_drained();

        if (q_val.size() != 0 || valid_sdeq != 1'b0) begin
            abort_run("instructions are still pending at the end of the run");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- src/istream_pkg.sv
// Sizes and shared types for the instruction stream buffer.
// Layout is fixed by the fetch block: 8 chunks of 16 bits per set.
`default_nettype none

package istream_pkg;

    // ------------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------------
    localparam int SETS      = 8;
    localparam int SET_IDX_W = 3;
    localparam int CHUNKS    = 8;
    localparam int WAYS      = 4;

    // fetch PC after reset
    localparam logic [31:0] INIT_PC = 32'h8000_0000;

    // ------------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------------

    // one instruction halfword
    typedef logic [15:0] chunk_t;

    // set index with wrap bit for full detection
    typedef struct packed {
        logic                 wrap;
        logic [SET_IDX_W-1:0] idx;
    } set_ptr_t;

    // block address without the chunk offset
    typedef logic [27:0] pc28_t;

    // how many sets leave the head this cycle
    typedef enum logic [1:0] {
        ADV_NONE = 2'd0,
        ADV_ONE  = 2'd1,
        ADV_TWO  = 2'd2
    } deq_adv_e;

endpackage

`default_nettype wire

//--- src/istream_ptrs.sv
// Enqueue and dequeue pointers of the set ring and the PC base of the head.
// Advance kind is already forced to none by way extraction while stalled.
`timescale 1ns/10ps
`default_nettype none

module istream_ptrs (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  restart,
    input  logic [31:0]           restart_pc,
    input  logic                  enq_fire,
    output logic                  stall_senq,
    output istream_pkg::set_ptr_t enq_idx,
    output istream_pkg::set_ptr_t deq0_idx,
    output istream_pkg::set_ptr_t deq1_idx,
    istream_rd_if.ptrs            rd
);

    istream_pkg::set_ptr_t enq_q;
    istream_pkg::set_ptr_t deq0_q;
    istream_pkg::pc28_t    pc28_q;
    logic                  full;

    // same slot, different lap
    assign full = (enq_q.idx == deq0_q.idx) && (enq_q.wrap != deq0_q.wrap);

    assign stall_senq = full;
    assign enq_idx    = enq_q;
    assign deq0_idx   = deq0_q;
    assign deq1_idx   = istream_pkg::set_ptr_t'(deq0_q + 4'd1);
    assign rd.deq0_pc28 = pc28_q;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            enq_q  <= '0;
            deq0_q <= '0;
            pc28_q <= istream_pkg::INIT_PC[31:4];
        end else if (restart) begin
            enq_q  <= '0;
            deq0_q <= '0;
            pc28_q <= restart_pc[31:4];
        end else begin
            if (enq_fire) begin
                enq_q <= istream_pkg::set_ptr_t'(enq_q + 4'd1);
            end
            // head base follows the last set that leaves
            case (rd.adv)
                istream_pkg::ADV_ONE: begin
                    deq0_q <= istream_pkg::set_ptr_t'(deq0_q + 4'd1);
                    pc28_q <= rd.deq0_after_pc28;
                end
                istream_pkg::ADV_TWO: begin
                    deq0_q <= istream_pkg::set_ptr_t'(deq0_q + 4'd2);
                    pc28_q <= rd.deq1_after_pc28;
                end
                default: begin
                end
            endcase
        end
    end

    // stall must block the fetch side before it overruns the head
    assert property (@(posedge CLK) disable iff (!nRST) enq_fire |-> !full)
        else $error("enqueue accepted while buffer full");

endmodule

`default_nettype wire

//--- src/istream_rd_if.sv
// Oldest two sets from storage to way extraction, plus the advance feedback.
// CLK is only used for assertion sampling on the way side.
`timescale 1ns/10ps
`default_nettype none

interface istream_rd_if (
    input logic CLK
);

    // oldest set
    istream_pkg::chunk_t [istream_pkg::CHUNKS-1:0] deq0_chunks;
    logic [istream_pkg::CHUNKS-1:0]                deq0_valid;
    logic [istream_pkg::CHUNKS-1:0]                deq0_uncomp;
    logic                                          deq0_occ;
    istream_pkg::pc28_t                            deq0_after_pc28;

    // set after it
    istream_pkg::chunk_t [istream_pkg::CHUNKS-1:0] deq1_chunks;
    logic [istream_pkg::CHUNKS-1:0]                deq1_valid;
    logic [istream_pkg::CHUNKS-1:0]                deq1_uncomp;
    logic                                          deq1_occ;
    istream_pkg::pc28_t                            deq1_after_pc28;

    // PC base of the oldest set
    istream_pkg::pc28_t deq0_pc28;

    // feedback from way extraction
    istream_pkg::deq_adv_e             adv;
    logic [2*istream_pkg::CHUNKS-1:0]  consume_mask;

    modport store (
        output deq0_chunks, deq0_valid, deq0_uncomp, deq0_occ, deq0_after_pc28,
        output deq1_chunks, deq1_valid, deq1_uncomp, deq1_occ, deq1_after_pc28,
        input  adv, consume_mask
    );

    modport ptrs (
        output deq0_pc28,
        input  adv, deq0_after_pc28, deq1_after_pc28
    );

    modport ways (
        input  CLK,
        input  deq0_chunks, deq0_valid, deq0_uncomp, deq0_occ, deq0_after_pc28,
        input  deq1_chunks, deq1_valid, deq1_uncomp, deq1_occ,
        input  deq0_pc28,
        output adv, consume_mask
    );

endinterface

`default_nettype wire

//--- src/istream_store.sv
// Set array of the stream buffer. Chunk data and addresses are held only
// while a set is occupied; valid maps of free sets are always zero.
`timescale 1ns/10ps
`default_nettype none

module istream_store (
    input  logic                                          CLK,
    input  logic                                          nRST,
    input  logic                                          restart,
    input  logic                                          enq_fire,
    input  istream_pkg::set_ptr_t                         enq_idx,
    input  istream_pkg::set_ptr_t                         deq0_idx,
    input  istream_pkg::set_ptr_t                         deq1_idx,
    input  logic [istream_pkg::CHUNKS-1:0]                valid_by_chunk_senq,
    input  istream_pkg::chunk_t [istream_pkg::CHUNKS-1:0] instr_by_chunk_senq,
    input  logic [31:0]                                   after_pc_senq,
    input  logic                                          stall_sdeq,
    istream_rd_if.store                                   rd
);

    // ------------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------------
    istream_pkg::chunk_t [istream_pkg::CHUNKS-1:0] data_q [istream_pkg::SETS];
    istream_pkg::pc28_t                            after_q [istream_pkg::SETS];
    logic [istream_pkg::SETS-1:0][istream_pkg::CHUNKS-1:0] uncomp_q;
    logic [istream_pkg::SETS-1:0][istream_pkg::CHUNKS-1:0] valid_q;
    logic [istream_pkg::SETS-1:0]                          occ_q;
    logic [istream_pkg::CHUNKS-1:0]                        enq_uncomp;

    // low bits 11 mark the lower half of a 32-bit instruction
    always_comb begin
        for (int i = 0; i < istream_pkg::CHUNKS; i++) begin
            enq_uncomp[i] = (instr_by_chunk_senq[i][1:0] == 2'b11);
        end
    end

    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            data_q[enq_idx.idx]   <= instr_by_chunk_senq;
            after_q[enq_idx.idx]  <= after_pc_senq[31:4];
            uncomp_q[enq_idx.idx] <= enq_uncomp;
        end
    end

    // ------------------------------------------------------------------------
    // occupancy and chunk valid maps
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            occ_q   <= '0;
            valid_q <= '0;
        end else if (restart) begin
            occ_q   <= '0;
            valid_q <= '0;
        end else begin
            if (!stall_sdeq) begin
                valid_q[deq0_idx.idx] <= valid_q[deq0_idx.idx] & ~rd.consume_mask[7:0];
                valid_q[deq1_idx.idx] <= valid_q[deq1_idx.idx] & ~rd.consume_mask[15:8];
            end
            if (rd.adv != istream_pkg::ADV_NONE) begin
                occ_q[deq0_idx.idx] <= 1'b0;
            end
            if (rd.adv == istream_pkg::ADV_TWO) begin
                occ_q[deq1_idx.idx] <= 1'b0;
            end
            // enqueue slot is never a busy head slot, so it wins
            if (enq_fire) begin
                occ_q[enq_idx.idx]   <= 1'b1;
                valid_q[enq_idx.idx] <= valid_by_chunk_senq;
            end
        end
    end

    // head view
    assign rd.deq0_chunks     = data_q[deq0_idx.idx];
    assign rd.deq0_valid      = valid_q[deq0_idx.idx];
    assign rd.deq0_uncomp     = uncomp_q[deq0_idx.idx];
    assign rd.deq0_occ        = occ_q[deq0_idx.idx];
    assign rd.deq0_after_pc28 = after_q[deq0_idx.idx];

    assign rd.deq1_chunks     = data_q[deq1_idx.idx];
    assign rd.deq1_valid      = valid_q[deq1_idx.idx];
    assign rd.deq1_uncomp     = uncomp_q[deq1_idx.idx];
    assign rd.deq1_occ        = occ_q[deq1_idx.idx];
    assign rd.deq1_after_pc28 = after_q[deq1_idx.idx];

    // way extraction must never consume a chunk that is not stored
    assert property (@(posedge CLK) disable iff (!nRST)
        !stall_sdeq |-> (rd.consume_mask & ~{rd.deq1_valid, rd.deq0_valid}) == '0)
        else $error("consume mask hits an invalid chunk");

endmodule

`default_nettype wire

//--- src/istream_top.sv
// Instruction stream buffer top: 8 sets of 8 chunks, 4 ways out per cycle.
// restart overrides enqueue and dequeue on the same edge.
`timescale 1ns/10ps
`default_nettype none

module istream_top (
    input  logic                                   CLK,
    input  logic                                   nRST,

    // enqueue side
    input  logic                                   valid_senq,
    input  logic [istream_pkg::CHUNKS-1:0]         valid_by_chunk_senq,
    input  logic [istream_pkg::CHUNKS-1:0][15:0]   instr_by_chunk_senq,
    input  logic [31:0]                            after_pc_senq,
    output logic                                   stall_senq,

    // dequeue side
    output logic                                   valid_sdeq,
    output logic [istream_pkg::WAYS-1:0]           valid_by_way_sdeq,
    output logic [istream_pkg::WAYS-1:0]           uncompressed_by_way_sdeq,
    output logic [istream_pkg::WAYS-1:0][31:0]     instr_by_way_sdeq,
    output logic [istream_pkg::WAYS-1:0][31:0]     pc_by_way_sdeq,
    input  logic                                   stall_sdeq,

    // redirect
    input  logic                                   restart,
    input  logic [31:0]                            restart_pc
);

    logic                  enq_fire;
    istream_pkg::set_ptr_t enq_idx;
    istream_pkg::set_ptr_t deq0_idx;
    istream_pkg::set_ptr_t deq1_idx;

    istream_rd_if rd (.CLK(CLK));

    assign enq_fire = valid_senq & ~stall_senq;

    istream_ptrs u_ptrs (
        .CLK        (CLK),
        .nRST       (nRST),
        .restart    (restart),
        .restart_pc (restart_pc),
        .enq_fire   (enq_fire),
        .stall_senq (stall_senq),
        .enq_idx    (enq_idx),
        .deq0_idx   (deq0_idx),
        .deq1_idx   (deq1_idx),
        .rd         (rd.ptrs)
    );

    istream_store u_store (
        .CLK                 (CLK),
        .nRST                (nRST),
        .restart             (restart),
        .enq_fire            (enq_fire),
        .enq_idx             (enq_idx),
        .deq0_idx            (deq0_idx),
        .deq1_idx            (deq1_idx),
        .valid_by_chunk_senq (valid_by_chunk_senq),
        .instr_by_chunk_senq (instr_by_chunk_senq),
        .after_pc_senq       (after_pc_senq),
        .stall_sdeq          (stall_sdeq),
        .rd                  (rd.store)
    );

    istream_ways u_ways (
        .rd                       (rd.ways),
        .stall_sdeq               (stall_sdeq),
        .valid_sdeq               (valid_sdeq),
        .valid_by_way_sdeq        (valid_by_way_sdeq),
        .uncompressed_by_way_sdeq (uncompressed_by_way_sdeq),
        .instr_by_way_sdeq        (instr_by_way_sdeq),
        .pc_by_way_sdeq           (pc_by_way_sdeq)
    );

endmodule

`default_nettype wire

//--- src/istream_ways.sv
// Splits the two oldest sets into up to four instructions in program order.
// Purely combinational; a 32-bit instruction may take its upper half from deq1.
`timescale 1ns/10ps
`default_nettype none

module istream_ways (
    istream_rd_if.ways                      rd,
    input  logic                            stall_sdeq,
    output logic                            valid_sdeq,
    output logic [istream_pkg::WAYS-1:0]    valid_by_way_sdeq,
    output logic [istream_pkg::WAYS-1:0]    uncompressed_by_way_sdeq,
    output logic [istream_pkg::WAYS-1:0][31:0] instr_by_way_sdeq,
    output logic [istream_pkg::WAYS-1:0][31:0] pc_by_way_sdeq
);

    // 16-chunk window with deq0 in the low half
    istream_pkg::chunk_t [2*istream_pkg::CHUNKS-1:0] win_chunk;
    logic [2*istream_pkg::CHUNKS-1:0] win_valid;
    logic [2*istream_pkg::CHUNKS-1:0] win_uncomp;
    logic [2*istream_pkg::CHUNKS-1:0] start_vec;
    logic [2*istream_pkg::CHUNKS-1:0] remaining;
    logic [2*istream_pkg::CHUNKS-1:0] consume;
    logic                             pend;

    logic [istream_pkg::WAYS-1:0][3:0] lo_idx;
    logic [istream_pkg::WAYS-1:0][3:0] up_idx;
    logic [istream_pkg::WAYS-1:0]      lo_found;
    logic [istream_pkg::WAYS-1:0]      up_found;
    logic [istream_pkg::WAYS-1:0]      way_uncomp;
    logic                              deq0_done;
    logic                              deq1_done;

    assign win_chunk  = {rd.deq1_chunks, rd.deq0_chunks};
    assign win_valid  = {rd.deq1_valid, rd.deq0_valid};
    assign win_uncomp = {rd.deq1_uncomp, rd.deq0_uncomp};

    // ------------------------------------------------------------------------
    // start marking
    // ------------------------------------------------------------------------
    // pend set while an uncompressed start waits for its upper half
    always_comb begin
        pend = 1'b0;
        for (int i = 0; i < 2 * istream_pkg::CHUNKS; i++) begin
            start_vec[i] = win_valid[i] & ~pend;
            if (win_valid[i]) begin
                pend = ~pend & win_uncomp[i];
            end
        end
    end

    // ------------------------------------------------------------------------
    // way pick
    // ------------------------------------------------------------------------
    always_comb begin
        remaining = start_vec;
        consume   = '0;
        for (int w = 0; w < istream_pkg::WAYS; w++) begin
            lo_found[w] = 1'b0;
            lo_idx[w]   = '0;
            for (int i = 0; i < 2 * istream_pkg::CHUNKS; i++) begin
                if (remaining[i] && !lo_found[w]) begin
                    lo_found[w] = 1'b1;
                    lo_idx[w]   = 4'(i);
                end
            end
            remaining[lo_idx[w]] = 1'b0;

            // upper half is the next valid chunk
            up_found[w] = 1'b0;
            up_idx[w]   = '0;
            for (int i = 0; i < 2 * istream_pkg::CHUNKS; i++) begin
                if (win_valid[i] && (i > int'(lo_idx[w])) && !up_found[w]) begin
                    up_found[w] = 1'b1;
                    up_idx[w]   = 4'(i);
                end
            end

            way_uncomp[w]        = lo_found[w] & win_uncomp[lo_idx[w]];
            valid_by_way_sdeq[w] = lo_found[w] & (~way_uncomp[w] | up_found[w]);
            if (valid_by_way_sdeq[w]) begin
                consume[lo_idx[w]] = 1'b1;
                if (way_uncomp[w]) begin
                    consume[up_idx[w]] = 1'b1;
                end
            end
        end
    end

    assign valid_sdeq               = valid_by_way_sdeq[0];
    assign uncompressed_by_way_sdeq = way_uncomp;
    assign rd.consume_mask          = consume;

    // instruction value and PC follow the lower chunk
    always_comb begin
        for (int w = 0; w < istream_pkg::WAYS; w++) begin
            if (way_uncomp[w]) begin
                instr_by_way_sdeq[w] = {win_chunk[up_idx[w]], win_chunk[lo_idx[w]]};
            end else begin
                instr_by_way_sdeq[w] = {16'h0000, win_chunk[lo_idx[w]]};
            end
            if (lo_idx[w][3]) begin
                pc_by_way_sdeq[w] = {rd.deq0_after_pc28, lo_idx[w][2:0], 1'b0};
            end else begin
                pc_by_way_sdeq[w] = {rd.deq0_pc28, lo_idx[w][2:0], 1'b0};
            end
        end
    end

    // ------------------------------------------------------------------------
    // set completion
    // ------------------------------------------------------------------------
    assign deq0_done = rd.deq0_occ & (&(~win_valid[7:0] | consume[7:0]));
    assign deq1_done = rd.deq1_occ & (&(~win_valid[15:8] | consume[15:8]));

    always_comb begin
        if (stall_sdeq) begin
            rd.adv = istream_pkg::ADV_NONE;
        end else if (deq0_done && deq1_done) begin
            rd.adv = istream_pkg::ADV_TWO;
        end else if (deq0_done) begin
            rd.adv = istream_pkg::ADV_ONE;
        end else begin
            rd.adv = istream_pkg::ADV_NONE;
        end
    end

    // occupied sets stay contiguous from the head of the ring
    assert property (@(posedge rd.CLK) rd.deq1_occ |-> rd.deq0_occ)
        else $error("set after the head is occupied while the head is free");

endmodule

`default_nettype wire
